// ==== src/trace_pkg.sv ====
`default_nettype none

package trace_pkg;

    // ##############################
    // Record kinds
    // ##############################

    // The numeric value doubles as the bit index in the kind mask
    typedef enum logic [2:0] {
        REC_INST = 3'd0,
        REC_MEM  = 3'd1,
        REC_REG  = 3'd2,
        REC_CSR  = 3'd3,
        REC_TRAP = 3'd4,
        REC_HALT = 3'd5
    } rec_kind_e;

    localparam int NUM_KINDS = 6;

    // Register addresses of the configuration port
    localparam logic CFG_CTRL  = 1'b0;
    localparam logic CFG_DROPS = 1'b1;

    // ##############################
    // Structures
    // ##############################

    // One cycle of the retirement port as sampled
    typedef struct packed {
        logic        valid;
        logic [1:0]  prv;
        logic        halted;
        logic        mxl64;
        logic [63:0] pc;
        logic [31:0] inst;
        logic        rd_wr;
        logic [4:0]  rd_addr;
        logic [63:0] rd_data;
        logic        len_64;
        logic        csr_wr;
        logic [11:0] csr_addr;
        logic [63:0] csr_data;
        logic        mem_req;
        logic        mem_wr;
        logic [7:0]  mem_byte;
        logic [63:0] mem_addr;
        logic [63:0] mem_rdata;
        logic [63:0] mem_wdata;
        logic        trap_en;
        logic [63:0] mcause;
        logic [63:0] epc;
        logic [63:0] mtval;
    } retire_info_t;

    // Normalized events of one retirement cycle
    typedef struct packed {
        logic [NUM_KINDS-1:0] flags;
        logic [1:0]           prv;
        logic                 dbg;
        logic [63:0]          pc;
        logic [31:0]          inst;
        logic [63:0]          mem_addr;
        logic [63:0]          mem_data;
        logic [7:0]           mem_mask;
        logic                 mem_wr;
        logic [4:0]           rd_addr;
        logic [63:0]          rd_data;
        logic [11:0]          csr_addr;
        logic [63:0]          csr_data;
        logic [63:0]          epc;
        logic [63:0]          mtval;
        logic [31:0]          cause_lo;
        logic                 halt_lvl;
    } trace_bundle_t;

    typedef struct packed {
        rec_kind_e   kind;
        logic [1:0]  prv;
        logic        dbg;
        logic [63:0] addr;
        logic [63:0] data;
        logic [31:0] aux;
    } trace_rec_t;

    typedef struct packed {
        logic                 enable;
        logic [NUM_KINDS-1:0] kind_mask;
    } cfg_t;

endpackage

`default_nettype wire

// ==== src/trace_cfg_regs.sv ====
`default_nettype none

module trace_cfg_regs (
    input  wire         clk,
    input  wire         arst_n,
    input  wire         cfg_wr,
    input  wire         cfg_addr,
    input  wire  [31:0] cfg_wdata,
    output logic [31:0] cfg_rdata,
    input  wire         drop,
    output trace_pkg::cfg_t cfg
);
    import trace_pkg::*;

    logic [31:0] drops_q;
    logic        wr_ctrl;
    logic        wr_drops;

    assign wr_ctrl  = cfg_wr && (cfg_addr == CFG_CTRL);
    assign wr_drops = cfg_wr && (cfg_addr == CFG_DROPS);

    // Tracing starts disabled but with every kind let through
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cfg.enable    <= 1'b0;
            cfg.kind_mask <= '1;
        end else if (wr_ctrl) begin
            cfg.enable    <= cfg_wdata[0];
            cfg.kind_mask <= cfg_wdata[NUM_KINDS:1];
        end
    end

    // A clear in the same cycle as a drop wins over the increment
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            drops_q <= '0;
        end else if (wr_drops) begin
            drops_q <= '0;
        end else if (drop && (drops_q != '1)) begin
            drops_q <= drops_q + 32'd1;
        end
    end

    always_comb begin
        if (cfg_addr == CFG_CTRL) begin
            cfg_rdata = {{(31 - NUM_KINDS){1'b0}}, cfg.kind_mask, cfg.enable};
        end else begin
            cfg_rdata = drops_q;
        end
    end

endmodule

`default_nettype wire

// ==== src/trace_fifo.sv ====
`default_nettype none

module trace_fifo #(
    parameter int  DEPTH     = 4,
    parameter type payload_t = logic [7:0]
) (
    input  wire           clk,
    input  wire           arst_n,
    input  wire           push,
    input  wire payload_t din,
    input  wire           pop,
    output payload_t      dout,
    output logic          empty,
    output logic          full
);

    localparam int AW = $clog2(DEPTH);

    payload_t    mem [DEPTH];
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic        do_push;
    logic        do_pop;

    // The extra top bit tells a full FIFO from an empty one
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // Head is visible before it is popped
    assign dout = mem[rd_ptr[AW-1:0]];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr[AW-1:0]] <= din;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
        end
    end

    a_no_overflow: assert property (
        @(posedge clk) disable iff (!arst_n) !(push && full)
    ) else $error("push into a full FIFO");

    a_no_underflow: assert property (
        @(posedge clk) disable iff (!arst_n) !(pop && empty)
    ) else $error("pop from an empty FIFO");

endmodule

`default_nettype wire

// ==== src/retire_capture.sv ====
`default_nettype none

module retire_capture (
    input  wire         clk,
    input  wire         arst_n,
    input  wire         valid,
    input  wire         mxl64,
    input  wire         len_64,
    input  wire  [63:0] pc,
    input  wire  [63:0] epc,
    input  wire  [31:0] inst,
    input  wire  [1:0]  prv,
    input  wire         rd_wr,
    input  wire  [4:0]  rd_addr,
    input  wire  [63:0] rd_data,
    input  wire         csr_wr,
    input  wire  [11:0] csr_waddr,
    input  wire  [63:0] csr_wdata,
    input  wire  [63:0] mem_addr,
    input  wire         mem_req,
    input  wire         mem_wr,
    input  wire  [7:0]  mem_byte,
    input  wire  [63:0] mem_rdata,
    input  wire  [63:0] mem_wdata,
    input  wire         trap_en,
    input  wire  [63:0] mcause,
    input  wire  [63:0] mtval,
    input  wire         halted,
    input  wire trace_pkg::cfg_t cfg,
    input  wire         bundle_full,
    output logic        bundle_push,
    output trace_pkg::trace_bundle_t bundle,
    output logic        drop
);
    import trace_pkg::*;

    retire_info_t         info_q;
    logic                 halted_prev_q;
    logic [NUM_KINDS-1:0] raw_flags;
    logic [63:0]          mem_src;

    // ##############################
    // Port sampling
    // ##############################

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            info_q        <= '0;
            halted_prev_q <= 1'b0;
        end else begin
            info_q <= '{valid: valid, prv: prv, halted: halted, mxl64: mxl64, pc: pc,
                        inst: inst, rd_wr: rd_wr, rd_addr: rd_addr, rd_data: rd_data,
                        len_64: len_64, csr_wr: csr_wr, csr_addr: csr_waddr,
                        csr_data: csr_wdata, mem_req: mem_req, mem_wr: mem_wr,
                        mem_byte: mem_byte, mem_addr: mem_addr, mem_rdata: mem_rdata,
                        mem_wdata: mem_wdata, trap_en: trap_en, mcause: mcause,
                        epc: epc, mtval: mtval};
            halted_prev_q <= info_q.halted;
        end
    end

    // ##############################
    // Normalization
    // ##############################

    assign mem_src = info_q.mem_wr ? info_q.mem_wdata : info_q.mem_rdata;

    always_comb begin
        raw_flags[REC_INST] = info_q.valid;
        raw_flags[REC_MEM]  = info_q.valid && info_q.mem_req;
        raw_flags[REC_REG]  = info_q.rd_wr;
        raw_flags[REC_CSR]  = info_q.csr_wr;
        raw_flags[REC_TRAP] = info_q.trap_en;
        raw_flags[REC_HALT] = info_q.halted ^ halted_prev_q;

        bundle.flags = raw_flags & cfg.kind_mask & {NUM_KINDS{cfg.enable}};
        bundle.prv   = info_q.prv;
        bundle.dbg   = info_q.halted;
        bundle.pc    = info_q.mxl64 ? info_q.pc : {32'b0, info_q.pc[31:0]};
        // Compressed encodings only occupy the low half
        bundle.inst  = (info_q.inst[1:0] == 2'b11) ? info_q.inst
                                                   : {16'b0, info_q.inst[15:0]};

        bundle.mem_addr = info_q.mem_addr & ~64'h3;
        for (int i = 0; i < 8; i++) begin
            bundle.mem_data[8*i +: 8] = info_q.mem_byte[i] ? mem_src[8*i +: 8] : 8'h00;
        end
        bundle.mem_mask = info_q.mem_byte;
        bundle.mem_wr   = info_q.mem_wr;

        bundle.rd_addr = info_q.rd_addr;
        if (info_q.rd_addr == 5'd0) begin
            bundle.rd_data = '0;
        end else if (!info_q.mxl64) begin
            bundle.rd_data = {32'b0, info_q.rd_data[31:0]};
        end else if (!info_q.len_64) begin
            bundle.rd_data = {{32{info_q.rd_data[31]}}, info_q.rd_data[31:0]};
        end else begin
            bundle.rd_data = info_q.rd_data;
        end

        bundle.csr_addr = info_q.csr_addr;
        bundle.csr_data = info_q.csr_data;
        bundle.epc      = info_q.epc;
        bundle.mtval    = info_q.mtval;
        bundle.cause_lo = info_q.mcause[31:0];
        bundle.halt_lvl = info_q.halted;
    end

    // Whole bundles are dropped so that a retirement is never split
    assign bundle_push = (|bundle.flags) && !bundle_full;
    assign drop        = (|bundle.flags) && bundle_full;

endmodule

`default_nettype wire

// ==== src/record_serializer.sv ====
`default_nettype none

module record_serializer (
    input  wire  clk,
    input  wire  arst_n,
    input  wire  bundle_empty,
    input  wire trace_pkg::trace_bundle_t bundle,
    output logic bundle_pop,
    input  wire  rec_full,
    output logic rec_push,
    output trace_pkg::trace_rec_t rec
);
    import trace_pkg::*;

    trace_bundle_t        hold_q;
    logic [NUM_KINDS-1:0] pend_q;
    logic [2:0]           kind_idx;

    // Next bundle is taken only after every record of the current one left
    assign bundle_pop = !bundle_empty && (pend_q == '0);
    assign rec_push   = (pend_q != '0) && !rec_full;

    // Lowest pending kind goes first
    always_comb begin
        kind_idx = 3'd0;
        for (int i = NUM_KINDS - 1; i >= 0; i--) begin
            if (pend_q[i]) kind_idx = 3'(i);
        end
    end

    always_ff @(posedge clk) begin
        if (bundle_pop) begin
            hold_q <= bundle;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pend_q <= '0;
        end else if (bundle_pop) begin
            pend_q <= bundle.flags;
        end else if (rec_push) begin
            // Clears exactly the lowest set bit
            pend_q <= pend_q & (pend_q - 1'b1);
        end
    end

    // ##############################
    // Record field mapping
    // ##############################

    always_comb begin
        rec.kind = rec_kind_e'(kind_idx);
        rec.prv  = hold_q.prv;
        rec.dbg  = hold_q.dbg;
        rec.addr = '0;
        rec.data = '0;
        rec.aux  = '0;
        case (rec_kind_e'(kind_idx))
            REC_INST: begin
                rec.addr = hold_q.pc;
                rec.aux  = hold_q.inst;
            end
            REC_MEM: begin
                rec.addr = hold_q.mem_addr;
                rec.data = hold_q.mem_data;
                rec.aux  = {23'b0, hold_q.mem_wr, hold_q.mem_mask};
            end
            REC_REG: begin
                rec.data = hold_q.rd_data;
                rec.aux  = {27'b0, hold_q.rd_addr};
            end
            REC_CSR: begin
                rec.data = hold_q.csr_data;
                rec.aux  = {20'b0, hold_q.csr_addr};
            end
            REC_TRAP: begin
                rec.addr = hold_q.epc;
                rec.data = hold_q.mtval;
                rec.aux  = hold_q.cause_lo;
            end
            REC_HALT: rec.data = {63'b0, hold_q.halt_lvl};
            default: ;
        endcase
    end

    // The emitted kind is pending and no lower kind is still waiting
    a_lowest_kind_first: assert property (
        @(posedge clk) disable iff (!arst_n)
        rec_push |-> pend_q[kind_idx] &&
                     ((pend_q & ((NUM_KINDS'(1) << kind_idx) - 1'b1)) == '0)
    ) else $error("emitted record is not the lowest pending kind");

endmodule

`default_nettype wire

// ==== src/cpu_trace_unit.sv ====
`default_nettype none

module cpu_trace_unit #(
    parameter int BUNDLE_DEPTH = 4,
    parameter int REC_DEPTH    = 8
) (
    input  wire         clk,
    input  wire         arst_n,
    input  wire         valid,
    input  wire         mxl64,
    input  wire         len_64,
    input  wire  [63:0] pc,
    input  wire  [63:0] epc,
    input  wire  [31:0] inst,
    input  wire  [1:0]  prv,
    input  wire         rd_wr,
    input  wire  [4:0]  rd_addr,
    input  wire  [63:0] rd_data,
    input  wire         csr_wr,
    input  wire  [11:0] csr_waddr,
    input  wire  [63:0] csr_wdata,
    input  wire  [63:0] mem_addr,
    input  wire         mem_req,
    input  wire         mem_wr,
    input  wire  [7:0]  mem_byte,
    input  wire  [63:0] mem_rdata,
    input  wire  [63:0] mem_wdata,
    input  wire         trap_en,
    input  wire  [63:0] mcause,
    input  wire  [63:0] mtval,
    input  wire         halted,
    input  wire         cfg_wr,
    input  wire         cfg_addr,
    input  wire  [31:0] cfg_wdata,
    output logic [31:0] cfg_rdata,
    output trace_pkg::trace_rec_t trace_rec,
    output logic        trace_empty,
    input  wire         trace_pop
);
    import trace_pkg::*;

    cfg_t          cfg;
    logic          drop;
    logic          bundle_push;
    trace_bundle_t bundle_in;
    trace_bundle_t bundle_head;
    logic          bundle_empty;
    logic          bundle_full;
    logic          bundle_pop;
    logic          rec_push;
    trace_rec_t    rec_in;
    logic          rec_full;

    trace_cfg_regs i_trace_cfg_regs (
        .clk       (clk),
        .arst_n    (arst_n),
        .cfg_wr    (cfg_wr),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata),
        .drop      (drop),
        .cfg       (cfg)
    );

    retire_capture i_retire_capture (
        .clk         (clk),
        .arst_n      (arst_n),
        .valid       (valid),
        .mxl64       (mxl64),
        .len_64      (len_64),
        .pc          (pc),
        .epc         (epc),
        .inst        (inst),
        .prv         (prv),
        .rd_wr       (rd_wr),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .csr_wr      (csr_wr),
        .csr_waddr   (csr_waddr),
        .csr_wdata   (csr_wdata),
        .mem_addr    (mem_addr),
        .mem_req     (mem_req),
        .mem_wr      (mem_wr),
        .mem_byte    (mem_byte),
        .mem_rdata   (mem_rdata),
        .mem_wdata   (mem_wdata),
        .trap_en     (trap_en),
        .mcause      (mcause),
        .mtval       (mtval),
        .halted      (halted),
        .cfg         (cfg),
        .bundle_full (bundle_full),
        .bundle_push (bundle_push),
        .bundle      (bundle_in),
        .drop        (drop)
    );

    trace_fifo #(
        .DEPTH     (BUNDLE_DEPTH),
        .payload_t (trace_bundle_t)
    ) i_bundle_fifo (
        .clk    (clk),
        .arst_n (arst_n),
        .push   (bundle_push),
        .din    (bundle_in),
        .pop    (bundle_pop),
        .dout   (bundle_head),
        .empty  (bundle_empty),
        .full   (bundle_full)
    );

    record_serializer i_record_serializer (
        .clk          (clk),
        .arst_n       (arst_n),
        .bundle_empty (bundle_empty),
        .bundle       (bundle_head),
        .bundle_pop   (bundle_pop),
        .rec_full     (rec_full),
        .rec_push     (rec_push),
        .rec          (rec_in)
    );

    trace_fifo #(
        .DEPTH     (REC_DEPTH),
        .payload_t (trace_rec_t)
    ) i_rec_fifo (
        .clk    (clk),
        .arst_n (arst_n),
        .push   (rec_push),
        .din    (rec_in),
        .pop    (trace_pop),
        .dout   (trace_rec),
        .empty  (trace_empty),
        .full   (rec_full)
    );

endmodule

`default_nettype wire

// ==== verif/tb_cpu_trace_unit.sv ====
`default_nettype none

module tb_cpu_trace_unit;
    timeunit 1ns;
    timeprecision 100ps;

    import trace_pkg::*;

    typedef trace_rec_t rec_q_t[$];

    localparam int EVENT_SAMPLES  = 24 + 24 + 30 + 24 + 8 + 12 * 4;
    localparam int OVF_SAMPLES    = 30;
    // Worst case spacing of one retirement is 2 * 6 + 5 cycles
    localparam int PLANNED_CYCLES = EVENT_SAMPLES * 17 + OVF_SAMPLES + 500;
    localparam int DRAIN_LIMIT    = 400;

    logic         clk;
    logic         arst_n;
    retire_info_t port;
    logic         cfg_wr;
    logic         cfg_addr;
    logic [31:0]  cfg_wdata;
    logic [31:0]  cfg_rdata;
    trace_rec_t   trace_rec;
    logic         trace_empty;
    logic         trace_pop = 1'b0;

    logic         pop_hold = 1'b0;
    logic         allow_drop = 1'b0;
    integer       seed = 32'hf050;
    cfg_t         tb_cfg;
    logic         last_halted;

    trace_rec_t   exp_recs[$];
    int           exp_sizes[$];
    int           grp_left;
    int           checks;
    int           errors;
    int           received;
    int           groups_sent;
    int           missing_groups;

    cpu_trace_unit i_cpu_trace_unit (
        .clk         (clk),
        .arst_n      (arst_n),
        .valid       (port.valid),
        .mxl64       (port.mxl64),
        .len_64      (port.len_64),
        .pc          (port.pc),
        .epc         (port.epc),
        .inst        (port.inst),
        .prv         (port.prv),
        .rd_wr       (port.rd_wr),
        .rd_addr     (port.rd_addr),
        .rd_data     (port.rd_data),
        .csr_wr      (port.csr_wr),
        .csr_waddr   (port.csr_addr),
        .csr_wdata   (port.csr_data),
        .mem_addr    (port.mem_addr),
        .mem_req     (port.mem_req),
        .mem_wr      (port.mem_wr),
        .mem_byte    (port.mem_byte),
        .mem_rdata   (port.mem_rdata),
        .mem_wdata   (port.mem_wdata),
        .trap_en     (port.trap_en),
        .mcause      (port.mcause),
        .mtval       (port.mtval),
        .halted      (port.halted),
        .cfg_wr      (cfg_wr),
        .cfg_addr    (cfg_addr),
        .cfg_wdata   (cfg_wdata),
        .cfg_rdata   (cfg_rdata),
        .trace_rec   (trace_rec),
        .trace_empty (trace_empty),
        .trace_pop   (trace_pop)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        #(PLANNED_CYCLES * 20 * 4);
        $display("Watchdog expired, the tests did not finish in the planned time");
        $display("Testbench failed");
        $finish;
    end

    // ##############################
    // Reference model
    // ##############################

    function automatic trace_rec_t make_rec(input rec_kind_e k, input retire_info_t s,
                                            input logic [63:0] a, input logic [63:0] d,
                                            input logic [31:0] x);
        trace_rec_t r;
        r.kind = k;
        r.prv  = s.prv;
        r.dbg  = s.halted;
        r.addr = a;
        r.data = d;
        r.aux  = x;
        return r;
    endfunction

    function automatic rec_q_t expected_records(input retire_info_t s, input cfg_t c,
                                                input logic prev_halted);
        rec_q_t      q;
        logic [63:0] src;
        logic [63:0] keep;
        logic [63:0] val;
        logic [63:0] pc_n;
        logic [31:0] inst_n;
        q = {};
        if (!c.enable) begin
            return q;
        end
        if (s.valid && c.kind_mask[REC_INST]) begin
            pc_n   = s.mxl64 ? s.pc : (s.pc & 64'h0000_0000_ffff_ffff);
            inst_n = (s.inst[1:0] == 2'b11) ? s.inst : (s.inst & 32'h0000_ffff);
            q.push_back(make_rec(REC_INST, s, pc_n, 64'd0, inst_n));
        end
        if (s.valid && s.mem_req && c.kind_mask[REC_MEM]) begin
            src  = s.mem_wr ? s.mem_wdata : s.mem_rdata;
            keep = '0;
            for (int b = 0; b < 8; b++) begin
                if (s.mem_byte[b]) keep[8*b +: 8] = 8'hff;
            end
            q.push_back(make_rec(REC_MEM, s, {s.mem_addr[63:2], 2'b00}, src & keep,
                                 {23'd0, s.mem_wr, s.mem_byte}));
        end
        if (s.rd_wr && c.kind_mask[REC_REG]) begin
            if (s.rd_addr == 5'd0) begin
                val = 64'd0;
            end else if (!s.mxl64) begin
                val = {32'd0, s.rd_data[31:0]};
            end else if (!s.len_64) begin
                val = 64'($signed(s.rd_data[31:0]));
            end else begin
                val = s.rd_data;
            end
            q.push_back(make_rec(REC_REG, s, 64'd0, val, {27'd0, s.rd_addr}));
        end
        if (s.csr_wr && c.kind_mask[REC_CSR]) begin
            q.push_back(make_rec(REC_CSR, s, 64'd0, s.csr_data, {20'd0, s.csr_addr}));
        end
        if (s.trap_en && c.kind_mask[REC_TRAP]) begin
            q.push_back(make_rec(REC_TRAP, s, s.epc, s.mtval, s.mcause[31:0]));
        end
        if ((s.halted != prev_halted) && c.kind_mask[REC_HALT]) begin
            q.push_back(make_rec(REC_HALT, s, 64'd0, {63'd0, s.halted}, 32'd0));
        end
        return q;
    endfunction

    // ##############################
    // Stimulus helpers
    // ##############################

    function automatic logic [63:0] rand64();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic logic coin();
        logic [63:0] r;
        r = rand64();
        return r[7];
    endfunction

    // Random payload with every strobe low and the halted level kept
    function automatic retire_info_t random_sample();
        retire_info_t s;
        logic [63:0]  r;
        s           = '0;
        r           = rand64();
        s.mxl64     = 1'b1;
        s.halted    = last_halted;
        s.prv       = r[1:0];
        s.rd_addr   = r[6:2];
        s.csr_addr  = r[18:7];
        s.mem_byte  = r[26:19];
        s.mem_wr    = r[27];
        s.len_64    = r[28];
        s.inst      = r[63:32];
        s.pc        = rand64();
        s.rd_data   = rand64();
        s.csr_data  = rand64();
        s.mem_addr  = rand64();
        s.mem_rdata = rand64();
        s.mem_wdata = rand64();
        s.mcause    = rand64();
        s.epc       = rand64();
        s.mtval     = rand64();
        return s;
    endfunction

    function automatic retire_info_t all_events_sample();
        retire_info_t s;
        s         = random_sample();
        s.valid   = 1'b1;
        s.mem_req = 1'b1;
        s.rd_wr   = 1'b1;
        s.csr_wr  = 1'b1;
        s.trap_en = 1'b1;
        s.halted  = ~last_halted;
        return s;
    endfunction

    task automatic drive_sample(input retire_info_t s, output int n);
        rec_q_t q;
        @(posedge clk);
        port <= s;
        q = expected_records(s, tb_cfg, last_halted);
        last_halted = s.halted;
        n = q.size();
        if (n > 0) begin
            foreach (q[k]) exp_recs.push_back(q[k]);
            exp_sizes.push_back(n);
            groups_sent++;
        end
    endtask

    task automatic idle(input int cycles);
        retire_info_t s;
        int           n;
        repeat (cycles) begin
            s        = '0;
            s.mxl64  = 1'b1;
            s.halted = last_halted;
            drive_sample(s, n);
        end
    endtask

    // Spacing keeps the consumer ahead so nothing is dropped
    task automatic drive_event(input retire_info_t s);
        int n;
        drive_sample(s, n);
        idle(2 * n + 4);
    endtask

    task automatic write_cfg(input logic a, input logic [31:0] d);
        @(posedge clk);
        cfg_wr    <= 1'b1;
        cfg_addr  <= a;
        cfg_wdata <= d;
        @(posedge clk);
        cfg_wr <= 1'b0;
        if (a == CFG_CTRL) begin
            tb_cfg.enable    = d[0];
            tb_cfg.kind_mask = d[6:1];
        end
    endtask

    task automatic read_cfg(input logic a, output logic [31:0] d);
        @(posedge clk);
        cfg_addr <= a;
        @(posedge clk);
        d = cfg_rdata;
    endtask

    // ##############################
    // Checking
    // ##############################

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("[FAIL] %0t ns %s: got %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_record(input trace_rec_t got);
        trace_rec_t exp;
        received++;
        if (grp_left == 0) begin
            // A dropped bundle shows up as a group whose first record never came
            while (allow_drop && exp_sizes.size() > 0 && exp_recs[0] != got) begin
                repeat (exp_sizes[0]) void'(exp_recs.pop_front());
                void'(exp_sizes.pop_front());
                missing_groups++;
            end
            if (exp_sizes.size() == 0) begin
                $display("Record of kind %0d at %0t ns arrived when none was expected",
                         got.kind, $time);
                errors++;
                return;
            end
            grp_left = exp_sizes.pop_front();
        end
        exp = exp_recs.pop_front();
        grp_left--;
        check_value("trace_rec.kind", {61'd0, got.kind}, {61'd0, exp.kind});
        check_value("trace_rec.prv", {62'd0, got.prv}, {62'd0, exp.prv});
        check_value("trace_rec.dbg", {63'd0, got.dbg}, {63'd0, exp.dbg});
        check_value("trace_rec.addr", got.addr, exp.addr);
        check_value("trace_rec.data", got.data, exp.data);
        check_value("trace_rec.aux", {32'd0, got.aux}, {32'd0, exp.aux});
    endtask

    // Pops every other cycle so a pop never meets an empty FIFO
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            trace_pop <= 1'b0;
        end else if (trace_pop) begin
            trace_pop <= 1'b0;
        end else if (!trace_empty && !pop_hold) begin
            trace_pop <= 1'b1;
            check_record(trace_rec);
        end
    end

    task automatic drain_records();
        int quiet;
        int waited;
        quiet  = 0;
        waited = 0;
        while (quiet < 20 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited++;
            if (trace_empty && !trace_pop) quiet++;
            else quiet = 0;
        end
        if (quiet < 20) begin
            $display("Trace output never went idle while draining at %0t ns", $time);
            errors++;
        end
        if (grp_left != 0) begin
            $display("A record group was only partly received, %0d records short", grp_left);
            errors++;
            grp_left = 0;
        end
    endtask

    task automatic end_test(input string name, input int e0);
        drain_records();
        if (exp_sizes.size() != 0) begin
            $display("%0d expected record groups never arrived", exp_sizes.size());
            errors++;
            exp_sizes.delete();
            exp_recs.delete();
        end
        $display("[TEST] %-10s done with %0d errors", name, errors - e0);
    endtask

    // ##############################
    // Test sequence
    // ##############################

    initial begin : main
        retire_info_t s;
        logic [31:0]  d;
        logic [5:0]   m;
        int           n;
        int           e0;
        port        = '0;
        cfg_wr      = 1'b0;
        cfg_addr    = 1'b0;
        cfg_wdata   = '0;
        arst_n      = 1'b0;
        last_halted = 1'b0;
        tb_cfg      = '{enable: 1'b0, kind_mask: '1};
        grp_left    = 0;
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;

        e0 = errors;
        @(posedge clk);
        check_value("trace_empty", {63'd0, trace_empty}, 64'd1);
        read_cfg(CFG_CTRL, d);
        check_value("cfg_rdata", {32'd0, d}, 64'h7e);
        read_cfg(CFG_DROPS, d);
        check_value("cfg_rdata", {32'd0, d}, 64'd0);
        write_cfg(CFG_CTRL, 32'h7f);
        end_test("reset", e0);

        e0 = errors;
        for (int i = 0; i < 24; i++) begin
            s        = random_sample();
            s.valid  = 1'b1;
            s.mxl64  = (i < 12);
            s.halted = (i % 8 >= 4);
            drive_event(s);
        end
        end_test("inst", e0);

        e0 = errors;
        for (int i = 0; i < 24; i++) begin
            s         = random_sample();
            s.valid   = 1'b1;
            s.mem_req = 1'b1;
            s.mxl64   = coin();
            drive_event(s);
        end
        end_test("mem", e0);

        e0 = errors;
        for (int i = 0; i < 30; i++) begin
            s        = (i % 6 == 0) ? all_events_sample() : random_sample();
            s.valid  = s.valid | coin();
            s.rd_wr  = 1'b1;
            s.csr_wr = s.csr_wr | coin();
            s.mxl64  = coin();
            if (i % 5 == 0) s.rd_addr = 5'd0;
            drive_event(s);
        end
        end_test("reg_csr", e0);

        e0 = errors;
        for (int i = 0; i < 24; i++) begin
            s         = random_sample();
            s.valid   = coin();
            s.trap_en = coin();
            s.halted  = coin();
            drive_event(s);
        end
        end_test("trap_halt", e0);

        e0 = errors;
        write_cfg(CFG_CTRL, 32'h7e);
        for (int i = 0; i < 8; i++) begin
            drive_event(all_events_sample());
        end
        for (int i = 0; i < 12; i++) begin
            m = (i < 6) ? (6'b1 << i) : ~(6'b1 << (i - 6));
            write_cfg(CFG_CTRL, {25'd0, m, 1'b1});
            read_cfg(CFG_CTRL, d);
            check_value("cfg_rdata", {32'd0, d}, {57'd0, m, 1'b1});
            repeat (4) drive_event(all_events_sample());
        end
        write_cfg(CFG_CTRL, 32'h7f);
        read_cfg(CFG_DROPS, d);
        check_value("cfg_rdata", {32'd0, d}, 64'd0);
        end_test("config", e0);

        e0 = errors;
        pop_hold   <= 1'b1;
        allow_drop <= 1'b1;
        for (int i = 0; i < OVF_SAMPLES; i++) begin
            s         = random_sample();
            s.valid   = 1'b1;
            s.rd_wr   = coin();
            s.mem_req = coin();
            drive_sample(s, n);
        end
        idle(10);
        pop_hold <= 1'b0;
        drain_records();
        // Groups still queued after the drain were dropped at the tail
        missing_groups += exp_sizes.size();
        exp_sizes.delete();
        exp_recs.delete();
        read_cfg(CFG_DROPS, d);
        check_value("cfg_rdata", {32'd0, d}, 64'(missing_groups));
        assert (missing_groups > 0) else begin
            $display("Overflow test dropped no bundle although the consumer was held off");
            errors++;
        end
        write_cfg(CFG_DROPS, 32'd0);
        read_cfg(CFG_DROPS, d);
        check_value("cfg_rdata", {32'd0, d}, 64'd0);
        allow_drop <= 1'b0;
        end_test("overflow", e0);

        $display("Checks %0d, records %0d, groups %0d, missing groups %0d, errors %0d",
                 checks, received, groups_sent, missing_groups, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== cpu_trace_unit.f ====
src/trace_pkg.sv
src/trace_cfg_regs.sv
src/trace_fifo.sv
src/retire_capture.sv
src/record_serializer.sv
src/cpu_trace_unit.sv
verif/tb_cpu_trace_unit.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_cpu_trace_unit \
    -f cpu_trace_unit.f \
    --Mdir obj_dir -o sim_cpu_trace_unit

./obj_dir/sim_cpu_trace_unit | tee sim.log

# The run counts as good only if the pass line was printed
grep -q "^Testbench passed$" sim.log
